//--- include/intt_config.svh
`ifndef INTT_CONFIG_SVH
`define INTT_CONFIG_SVH

// modulus of the coefficient ring.
`define INTT_Q 7681

`define INTT_COEFF_W 16

// lanes per block, also the number of blocks per frame.
`define INTT_N 16
`define INTT_LOG_N 4

// 62 has order 512 mod q, so 62^32 has order 16.
`define INTT_W_INV 7154

// 16 * 7201 = 15 * 7681 + 1.
`define INTT_N_INV 7201

// four butterfly stages plus the scaling stage.
`define INTT_CORE_LAT 5

`endif

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module intt_tb -f tb.f -o intt_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/intt_sim > sim.log 2>&1 || echo "simulator exited with an error"
grep -q -F '*** FAILED ***' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q -F '*** PASSED ***' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

//--- source/corner_turn_buffer.sv
`include "intt_config.svh"

module corner_turn_buffer
	import intt_pkg::*;
(
	input  logic         clk,
	input  logic         wr_en,
	input  lane_idx_t    wr_row,
	input  coeff_block_t wr_block,
	input  lane_idx_t    rd_col,
	output coeff_block_t rd_block
);

	coeff_block_t mem [`INTT_N]; // one row per input block.

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_row] <= wr_block;
		end
	end

	// column gather, lane p comes from row p.
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < `INTT_N; p++)
		begin
			rd_block.lane[p] <= mem[p].lane[rd_col];
		end
	end

endmodule

//--- source/intt16_core.sv
`include "intt_config.svh"

module intt16_core
	import intt_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         in_valid,
	input  coeff_block_t in_vec,
	output logic         out_valid,
	output coeff_block_t out_vec
);

	coeff_t stg [`INTT_LOG_N+1][`INTT_N]; // stg[0] is the input, stg[4] is bit-reversed.
	logic [`INTT_CORE_LAT-1:0] vld_q;

	for (genvar i = 0; i < `INTT_N; i++)
	begin : g_in
		assign stg[0][i] = in_vec.lane[i];
	end

	for (genvar s = 0; s < `INTT_LOG_N; s++)
	begin : g_stage
		localparam int H = (`INTT_N / 2) >> s;

		for (genvar bi = 0; bi < `INTT_N / 2; bi++)
		begin : g_bf
			localparam int TOP = (bi / H) * 2 * H + bi % H;
			localparam int BOT = TOP + H;
			localparam coeff_t TW = twiddle(s, bi);

			inv_butterfly u_bf
			(
				.clk  (clk),
				.a    (stg[s][TOP]),
				.b    (stg[s][BOT]),
				.w    (TW),
				.sum  (stg[s+1][TOP]),
				.diff (stg[s+1][BOT])
			);
		end
	end

	// scale by 1/16 and undo the bit-reversed order.
	always_ff @(posedge clk)
	begin
		for (int k = 0; k < `INTT_N; k++)
		begin
			out_vec.lane[k] <= mod_mul(stg[`INTT_LOG_N][bitrev4(lane_idx_t'(k))],
				coeff_t'(`INTT_N_INV));
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vld_q <= '0;
		end
		else
		begin
			vld_q <= {vld_q[`INTT_CORE_LAT-2:0], in_valid};
		end
	end

	assign out_valid = vld_q[`INTT_CORE_LAT-1];

endmodule

//--- source/intt_ctrl.sv
`include "intt_config.svh"

module intt_ctrl
	import intt_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         in_req,
	input  coeff_block_t in_block,
	output logic         in_ack,
	output logic         out_req,
	output coeff_block_t out_block,
	input  logic         out_ack,
	output logic         wr_en,
	output lane_idx_t    wr_row,
	output coeff_block_t wr_block,
	output lane_idx_t    rd_col,
	output logic         core_valid,
	input  logic         res_valid,
	input  coeff_block_t res_block
);

	typedef enum logic [2:0]
	{
		S_FILL,
		S_FILL_ACK,
		S_READ,
		S_WAIT,
		S_OUT,
		S_OUT_REL
	} state_t;

	state_t    state;
	lane_idx_t blk_cnt;
	lane_idx_t out_cnt;

	assign in_ack  = (state == S_FILL_ACK);
	assign out_req = (state == S_OUT);

	assign wr_en  = (state == S_FILL) && in_req; // write on the edge that raises in_ack.
	assign wr_row = bitrev4(blk_cnt);
	assign rd_col = bitrev4(out_cnt);

	always_comb
	begin
		for (int k = 0; k < `INTT_N; k++)
		begin
			wr_block.lane[k] = in_block.lane[bitrev4(lane_idx_t'(k))];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state      <= S_FILL;
			blk_cnt    <= '0;
			out_cnt    <= '0;
			core_valid <= 1'b0;
		end
		else
		begin
			core_valid <= (state == S_READ); // buffer data is valid one cycle after the read.
			case (state)
				S_FILL:
					if (in_req)
					begin
						state <= S_FILL_ACK;
					end
				S_FILL_ACK:
					if (!in_req)
					begin
						blk_cnt <= blk_cnt + 1'b1; // wraps to 0 after the last block.
						state   <= (blk_cnt == lane_idx_t'(`INTT_N - 1)) ? S_READ : S_FILL;
					end
				S_READ:
					state <= S_WAIT;
				S_WAIT:
					if (res_valid)
					begin
						state <= S_OUT;
					end
				S_OUT:
					if (out_ack)
					begin
						state <= S_OUT_REL;
					end
				S_OUT_REL:
					if (!out_ack)
					begin
						out_cnt <= out_cnt + 1'b1;
						state   <= (out_cnt == lane_idx_t'(`INTT_N - 1)) ? S_FILL : S_READ;
					end
				default:
					state <= S_FILL;
			endcase
		end
	end

	// holding register, stable for the whole output handshake.
	always_ff @(posedge clk)
	begin
		if (state == S_WAIT && res_valid)
		begin
			out_block <= res_block;
		end
	end

endmodule

//--- source/intt_pkg.sv
`include "intt_config.svh"

package intt_pkg;

	typedef logic [`INTT_COEFF_W-1:0] coeff_t;
	typedef logic [`INTT_LOG_N-1:0] lane_idx_t;

	typedef struct packed
	{
		coeff_t [`INTT_N-1:0] lane;
	} coeff_block_t;

	function automatic lane_idx_t bitrev4(input lane_idx_t i);
		return {i[0], i[1], i[2], i[3]};
	endfunction

	function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
		logic [`INTT_COEFF_W:0] s;
		s = a + b;
		if (s >= `INTT_Q)
		begin
			s = s - `INTT_Q;
		end
		return coeff_t'(s);
	endfunction

	function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
		if (a >= b)
		begin
			return coeff_t'(a - b);
		end
		return coeff_t'(a + `INTT_Q - b);
	endfunction

	function automatic coeff_t mod_mul(input coeff_t a, input coeff_t b);
		logic [2*`INTT_COEFF_W-1:0] p;
		p = a * b;
		return coeff_t'(p % `INTT_Q);
	endfunction

	// W^(j << stage) for butterfly idx of a decimation-in-frequency stage.
	function automatic coeff_t twiddle(input int stage, input int idx);
		int h;
		int e;
		coeff_t r;
		h = (`INTT_N / 2) >> stage;
		e = (idx % h) << stage;
		r = 1;
		for (int n = 0; n < e; n++)
		begin
			r = mod_mul(r, coeff_t'(`INTT_W_INV));
		end
		return r;
	endfunction

endpackage

//--- source/intt_top.sv
module intt_top
	import intt_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         in_req,
	input  coeff_block_t in_block,
	output logic         in_ack,
	output logic         out_req,
	output coeff_block_t out_block,
	input  logic         out_ack
);

	logic         wr_en;
	lane_idx_t    wr_row;
	coeff_block_t wr_block;
	lane_idx_t    rd_col;
	coeff_block_t rd_block;
	logic         core_valid;
	logic         res_valid;
	coeff_block_t res_block;

	intt_ctrl u_ctrl
	(
		.clk        (clk),
		.rst        (rst),
		.in_req     (in_req),
		.in_block   (in_block),
		.in_ack     (in_ack),
		.out_req    (out_req),
		.out_block  (out_block),
		.out_ack    (out_ack),
		.wr_en      (wr_en),
		.wr_row     (wr_row),
		.wr_block   (wr_block),
		.rd_col     (rd_col),
		.core_valid (core_valid),
		.res_valid  (res_valid),
		.res_block  (res_block)
	);

	corner_turn_buffer u_buf
	(
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_row   (wr_row),
		.wr_block (wr_block),
		.rd_col   (rd_col),
		.rd_block (rd_block)
	);

	intt16_core u_core
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (core_valid),
		.in_vec    (rd_block), // column read arrives with core_valid.
		.out_valid (res_valid),
		.out_vec   (res_block)
	);

endmodule

//--- source/inv_butterfly.sv
module inv_butterfly
	import intt_pkg::*;
(
	input  logic   clk,
	input  coeff_t a,
	input  coeff_t b,
	input  coeff_t w,
	output coeff_t sum,
	output coeff_t diff
);

	coeff_t d;

	assign d = mod_sub(a, b);

	// Gentleman-Sande, twiddle applied after the subtraction.
	always_ff @(posedge clk)
	begin
		sum  <= mod_add(a, b);
		diff <= mod_mul(d, w);
	end

endmodule

//--- tb.f
+incdir+include
source/intt_pkg.sv
source/inv_butterfly.sv
source/corner_turn_buffer.sv
source/intt16_core.sv
source/intt_ctrl.sv
source/intt_top.sv
verification/intt_props.sv
verification/intt_tb.sv

//--- verification/intt_props.sv
module intt_props
	import intt_pkg::*;
(
	input logic         clk,
	input logic         rst,
	input logic         in_req,
	input logic         in_ack,
	input logic         out_req,
	input logic         out_ack,
	input coeff_block_t out_block
);

	timeunit 1ns;
	timeprecision 1ps;

	in_req_held: assert property (@(posedge clk) disable iff (rst)
		in_req && !in_ack |=> in_req)
		else $error("in_req dropped before in_ack was raised");

	out_req_held: assert property (@(posedge clk) disable iff (rst)
		out_req && !out_ack |=> out_req)
		else $error("out_req dropped before out_ack was raised");

	// holding register must not move under an open request.
	out_block_stable: assert property (@(posedge clk) disable iff (rst)
		out_req |=> !out_req || $stable(out_block))
		else $error("out_block changed while out_req was high");

	reset_quiet: assert property (@(posedge clk)
		rst |=> !in_ack && !out_req)
		else $error("in_ack or out_req high in the cycle after reset");

endmodule

//--- verification/intt_tb.sv
`include "intt_config.svh"

module intt_tb
	import intt_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT   = 2000; // long enough for a slow drain.
	localparam int SLOW_ACK     = 8;
	localparam int FRAME_ZERO   = 0;
	localparam int FRAME_IMPULSE = 1;
	localparam int FRAME_RANDOM = 2;

	logic         clk;
	logic         rst;
	logic         in_req;
	coeff_block_t in_block;
	logic         in_ack;
	logic         out_req;
	coeff_block_t out_block;
	logic         out_ack;

	integer       seed;
	int           value_errors;
	int           timeout_errors;
	int           protocol_errors;
	int           in_done;
	int           out_done;
	int           out_reqs;
	int           frames;
	logic         in_ack_d;
	logic         out_ack_d;
	logic         out_req_d;
	longint       w_pow [256];
	coeff_block_t src_frame [`INTT_N];
	coeff_block_t exp_frame [`INTT_N];

	intt_top dut_i
	(
		.clk       (clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_block  (in_block),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_block (out_block),
		.out_ack   (out_ack)
	);

	bind intt_top intt_props props_i
	(
		.clk       (clk),
		.rst       (rst),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_block (out_block)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// handshake counters and ordering rules between fill and drain.
	always @(posedge clk)
	begin
		if (rst)
		begin
			in_ack_d  <= 1'b0;
			out_ack_d <= 1'b0;
			out_req_d <= 1'b0;
		end
		else
		begin
			in_ack_d  <= in_ack;
			out_ack_d <= out_ack;
			out_req_d <= out_req;
			if (in_ack_d && !in_ack)
			begin
				in_done <= in_done + 1;
			end
			if (out_ack_d && !out_ack)
			begin
				out_done <= out_done + 1;
			end
			if (out_req && !out_req_d)
			begin
				out_reqs <= out_reqs + 1;
			end
			if (in_ack && out_done < `INTT_N * (in_done / `INTT_N))
			begin
				$display("in_ack raised at %0t while the previous frame was still draining",
					$time);
				protocol_errors++;
			end
			if (out_req && in_done < `INTT_N * (out_done / `INTT_N + 1))
			begin
				$display("out_req raised at %0t before the frame was fully accepted", $time);
				protocol_errors++;
			end
		end
	end

	function automatic int reverse_index(input int i);
		int r;
		r = 0;
		for (int b = 0; b < `INTT_LOG_N; b++)
		begin
			r = (r << 1) | ((i >> b) & 1);
		end
		return r;
	endfunction

	// direct sum where element p of vector m is element m of block bitrev(p).
	function automatic coeff_block_t model_block(input int m);
		coeff_block_t r;
		longint acc;
		longint v;
		for (int k = 0; k < `INTT_N; k++)
		begin
			acc = 0;
			for (int p = 0; p < `INTT_N; p++)
			begin
				v   = longint'(src_frame[reverse_index(p)].lane[m]);
				acc = (acc + v * w_pow[p * k]) % `INTT_Q;
			end
			r.lane[k] = coeff_t'((acc * `INTT_N_INV) % `INTT_Q);
		end
		return r;
	endfunction

	task automatic build_expected();
		for (int m = 0; m < `INTT_N; m++)
		begin
			exp_frame[m] = model_block(m);
		end
	endtask

	task automatic make_frame(input int kind);
		for (int i = 0; i < `INTT_N; i++)
		begin
			for (int k = 0; k < `INTT_N; k++)
			begin
				if (kind == FRAME_RANDOM)
				begin
					src_frame[i].lane[k] = coeff_t'($unsigned($random(seed)) % `INTT_Q);
				end
				else
				begin
					src_frame[i].lane[k] = '0;
				end
			end
		end
		if (kind == FRAME_IMPULSE)
		begin
			src_frame[0].lane[0] = coeff_t'(1);
		end
	endtask

	task automatic compare_block(input coeff_block_t got, input coeff_block_t want,
		input int m);
		for (int k = 0; k < `INTT_N; k++)
		begin
			if (got.lane[k] !== want.lane[k])
			begin
				$display("Error at %0t: output block %0d lane %0d is %0d, expected %0d",
					$time, m, k, got.lane[k], want.lane[k]);
				value_errors++;
			end
		end
	endtask

	task automatic wait_in_ack(input logic level);
		int n;
		n = 0;
		while (in_ack !== level && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (in_ack !== level)
		begin
			$display("timeout: in_ack did not go to %0d within %0d cycles", level, WAIT_LIMIT);
			timeout_errors++;
		end
	endtask

	task automatic wait_out_req(input logic level);
		int n;
		n = 0;
		while (out_req !== level && n < WAIT_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (out_req !== level)
		begin
			$display("timeout: out_req did not go to %0d within %0d cycles", level, WAIT_LIMIT);
			timeout_errors++;
		end
	endtask

	task automatic send_block(input coeff_block_t blk);
		in_req   <= 1'b1;
		in_block <= blk;
		wait_in_ack(1'b1);
		in_req <= 1'b0;
		wait_in_ack(1'b0);
	endtask

	task automatic send_frame();
		@(posedge clk);
		for (int i = 0; i < `INTT_N; i++)
		begin
			send_block(src_frame[i]);
		end
	endtask

	task automatic receive_frame(input int extra_delay);
		coeff_block_t got;
		int d;
		for (int m = 0; m < `INTT_N; m++)
		begin
			wait_out_req(1'b1);
			got = out_block;
			compare_block(got, exp_frame[m], m);
			d = $unsigned($random(seed)) % 6 + extra_delay;
			repeat (d) @(posedge clk);
			out_ack <= 1'b1;
			wait_out_req(1'b0);
			out_ack <= 1'b0;
		end
	endtask

	task automatic check_quiet(input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			@(posedge clk);
			if (out_req !== 1'b0 || in_ack !== 1'b0)
			begin
				$display("out_req or in_ack high at %0t with no frame in progress", $time);
				protocol_errors++;
			end
		end
	endtask

	task automatic check_output_count();
		if (out_reqs != `INTT_N * frames)
		begin
			$display("%0d output requests seen after %0d frames", out_reqs, frames);
			protocol_errors++;
		end
	endtask

	task automatic run_frame(input int kind);
		make_frame(kind);
		build_expected();
		send_frame();
		receive_frame(0);
		frames++;
		check_output_count();
	endtask

	initial
	begin
		seed            = 32'hf413;
		value_errors    = 0;
		timeout_errors  = 0;
		protocol_errors = 0;
		in_done         = 0;
		out_done        = 0;
		out_reqs        = 0;
		frames          = 0;
		rst             = 1'b1;
		in_req          = 1'b0;
		in_block        = '0;
		out_ack         = 1'b0;
		w_pow[0]        = 1;
		for (int e = 1; e < 256; e++)
		begin
			w_pow[e] = (w_pow[e - 1] * `INTT_W_INV) % `INTT_Q;
		end

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		check_quiet(20);

		run_frame(FRAME_ZERO);
		run_frame(FRAME_IMPULSE);
		run_frame(FRAME_RANDOM);
		run_frame(FRAME_RANDOM);

		// third random frame drains slowly while the next one is offered.
		make_frame(FRAME_RANDOM);
		build_expected();
		send_frame();
		make_frame(FRAME_RANDOM);
		fork
			receive_frame(SLOW_ACK);
			send_frame();
		join
		frames++;
		check_output_count();
		build_expected();
		receive_frame(0);
		frames++;
		check_output_count();

		check_quiet(20);
		$display("error counts: %0d value, %0d timeout, %0d protocol",
			value_errors, timeout_errors, protocol_errors);
		if (value_errors + timeout_errors + protocol_errors == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
